//--- exu.f
verilog/exu_pkg.sv
verilog/exu_regfile.sv
verilog/exu_decode.sv
verilog/exu_disp.sv
verilog/exu_oitf.sv
verilog/exu_alu.sv
verilog/exu_wbck.sv
verilog/exu.sv
testbench/tb_exu.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f exu.f --top-module tb_exu -o tb_exu_sim

out=$(./obj_dir/tb_exu_sim)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

//--- testbench/tb_exu.sv
// Runs with the default OITF_DEPTH of 4; the load/store-unit model returns loads in order
`timescale 1ns/1ps

module tb_exu;
  import exu_pkg::*;

  localparam int MAX_ENT    = 96;
  localparam int OITF_DEPTH = 4;

  typedef enum logic [1:0] {K_ALU, K_LD, K_ILL} kind_e;

  // One row of the program table
  typedef struct packed {
    logic [31:0] ir;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] pc;
    kind_e       kind;
    logic        use_rs1;
    logic        use_rs2;
    logic        drain;  // Wait for an empty OITF before issue
    logic [4:0]  rd;
    logic [31:0] addr;   // Expected load address
    logic [31:0] val;    // Expected write-back data
  } entry_t;

  logic        clk;
  logic        i_arst_n;
  logic        i_valid;
  logic        o_ready;
  instr_u      i_ir;
  logic [31:0] i_pc;
  logic [4:0]  i_rs1idx;
  logic [4:0]  i_rs2idx;
  logic        o_agu_valid;
  logic        i_agu_ready;
  agu_req_t    o_agu_req;
  logic        i_lsu_valid;
  logic        o_lsu_ready;
  lsu_wbck_t   i_lsu_wbck;
  rf_wbck_t    o_rf_wbck;
  logic        o_trap;
  logic [31:0] o_trap_pc;
  logic        o_oitf_empty;
  logic        o_exu_active;

  entry_t      tbl [MAX_ENT];
  logic [31:0] gold [32];
  entry_t      ld_pend [$];  // Accepted loads not yet written back
  lsu_wbck_t   lsu_q [$];
  int          lsu_due [$];
  int          n_tbl = 0;
  int          n_chk = 0;
  int          n_err = 0;
  int          n_ld = 0;
  int          n_ovl = 0;  // Loads accepted behind an outstanding one
  int          cyc = 0;
  int          limit = 0;

  exu #(.OITF_DEPTH(OITF_DEPTH)) i_exu (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_valid(i_valid), .o_ready(o_ready), .i_ir(i_ir), .i_pc(i_pc),
    .i_rs1idx(i_rs1idx), .i_rs2idx(i_rs2idx),
    .o_agu_valid(o_agu_valid), .i_agu_ready(i_agu_ready), .o_agu_req(o_agu_req),
    .i_lsu_valid(i_lsu_valid), .o_lsu_ready(o_lsu_ready), .i_lsu_wbck(i_lsu_wbck),
    .o_rf_wbck(o_rf_wbck), .o_trap(o_trap), .o_trap_pc(o_trap_pc),
    .o_oitf_empty(o_oitf_empty), .o_exu_active(o_exu_active)
  );

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_chk++;
    if (got !== exp) begin
      n_err++;
      $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // RV32I result by funct3, alt selects SUB or SRA
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Golden model runs in program order while the table is built
  task automatic add_entry(input logic [31:0] ir, input logic drain);
    entry_t      e;
    logic [31:0] a;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    e       = '0;
    f3      = ir[14:12];
    f7      = ir[31:25];
    e.ir    = ir;
    e.rs1   = ir[19:15];
    e.rs2   = ir[24:20];
    e.rd    = ir[11:7];
    e.pc    = 32'h0000_1000 + 32'(n_tbl * 4);
    e.drain = drain;
    e.kind  = K_ILL;
    a       = gold[e.rs1];
    imm     = {{20{ir[31]}}, ir[31:20]};
    case (ir[6:0])
      OPC_OP: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          e.kind    = K_ALU;
          e.use_rs1 = 1'b1;
          e.use_rs2 = 1'b1;
          e.val     = alu_ref(f3, f7[5], a, gold[e.rs2]);
        end
      end
      OPC_OP_IMM: begin
        // Shift immediates keep a funct7 field
        if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
          e.kind    = K_ALU;
          e.use_rs1 = 1'b1;
          e.val     = alu_ref(f3, f7[5] && (f3 == 3'd5), a, imm);
        end
      end
      OPC_LUI: begin
        e.kind = K_ALU;
        e.val  = {ir[31:12], 12'h000};
      end
      OPC_LOAD: begin
        if (f3 == 3'd2) begin
          e.kind    = K_LD;
          e.use_rs1 = 1'b1;
          e.addr    = a + imm;
          e.val     = e.addr ^ 32'h5A5A_0000;  // Memory contents rule
        end
      end
      default: ;
    endcase
    if (e.kind != K_ILL && e.rd != 5'd0) gold[e.rd] = e.val;
    tbl[n_tbl] = e;
    n_tbl++;
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load/store-unit model, in-order returns after 0 to 3 cycles

  initial begin : lsu_model
    lsu_wbck_t rsp;
    logic      req_fire;
    logic      rsp_fire;
    void'($urandom(70498));
    i_agu_ready = 1'b0;
    i_lsu_valid = 1'b0;
    i_lsu_wbck  = '0;
    forever begin
      @(negedge clk);
      req_fire = o_agu_valid && i_agu_ready;
      rsp_fire = i_lsu_valid && o_lsu_ready;
      if (req_fire) begin
        rsp.wdat = o_agu_req.addr ^ 32'h5A5A_0000;
        rsp.itag = o_agu_req.itag;
        lsu_q.push_back(rsp);
        lsu_due.push_back(cyc + 1 + int'($urandom_range(0, 3)));
      end
      @(posedge clk);
      #1;
      if (rsp_fire) begin
        void'(lsu_q.pop_front());
        void'(lsu_due.pop_front());
      end
      i_agu_ready = ($urandom_range(0, 3) != 0);
      i_lsu_valid = (lsu_q.size() != 0) && (cyc >= lsu_due[0]);
      if (lsu_q.size() != 0) i_lsu_wbck = lsu_q[0];
    end
  end

  // Load write-back check; the entry leaves the queue at the accepting edge
  initial begin : wbck_monitor
    logic fire;
    forever begin
      @(negedge clk);
      fire = i_arst_n && i_lsu_valid && o_lsu_ready;
      if (fire && ld_pend.size() == 0) begin
        n_err++;
        $display("load return accepted at %0t ns with no load outstanding", $time);
      end else if (fire) begin
        check_val("o_rf_wbck.ena", o_rf_wbck.ena, 1'b1);
        check_val("o_rf_wbck.rdidx", o_rf_wbck.rdidx, ld_pend[0].rd);
        check_val("o_rf_wbck.wdat", o_rf_wbck.wdat, ld_pend[0].val);
      end
      // Busy while an instruction is offered or a load is in flight
      if (i_arst_n) begin
        check_val("o_exu_active", o_exu_active, i_valid || (ld_pend.size() != 0));
      end
      @(posedge clk);
      if (fire && ld_pend.size() != 0) void'(ld_pend.pop_front());
    end
  end

  initial begin : watchdog
    while (limit == 0 || cyc <= limit) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("checks %0d, errors %0d", n_chk, n_err + 1);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Program table and driver

  initial begin : driver
    entry_t e;
    logic   hit;
    i_arst_n    = 1'b0;
    i_valid     = 1'b0;
    i_ir        = '0;
    i_pc        = '0;
    i_rs1idx    = '0;
    i_rs2idx    = '0;
    foreach (gold[i]) gold[i] = '0;

    add_entry(r_type(7'h00, 3'd6, 5'd0, 5'd5, 5'd0), 1'b0);   // Reads after reset
    add_entry(r_type(7'h00, 3'd6, 5'd0, 5'd31, 5'd0), 1'b0);
    add_entry(i_type(OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'h123), 1'b0);
    add_entry(i_type(OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'hF85), 1'b0);
    add_entry({20'h87654, 5'd3, OPC_LUI}, 1'b0);
    add_entry(i_type(OPC_OP_IMM, 3'd0, 5'd3, 5'd3, 12'h321), 1'b0);
    for (int f = 0; f < 8; f++) begin
      add_entry(r_type(7'h00, 3'(f), 5'(4 + f), 5'd3, 5'd2), 1'b0);
      add_entry(i_type(OPC_OP_IMM, 3'(f), 5'(12 + f), 5'd2,
                       (f == 1 || f == 5) ? 12'h007 : 12'hA5C), 1'b0);
    end
    add_entry(r_type(7'h20, 3'd0, 5'd20, 5'd1, 5'd3), 1'b0);  // SUB
    add_entry(r_type(7'h20, 3'd5, 5'd21, 5'd3, 5'd1), 1'b0);  // SRA
    add_entry(i_type(OPC_OP_IMM, 3'd5, 5'd22, 5'd3, 12'h40C), 1'b0);
    add_entry(i_type(OPC_OP_IMM, 3'd0, 5'd0, 5'd1, 12'h037), 1'b0);  // Lost in x0
    add_entry(r_type(7'h00, 3'd0, 5'd23, 5'd0, 5'd0), 1'b0);
    // Five loads against four table entries
    add_entry(i_type(OPC_LOAD, 3'd2, 5'd24, 5'd1, 12'h010), 1'b0);
    add_entry(i_type(OPC_LOAD, 3'd2, 5'd25, 5'd2, 12'hFF8), 1'b0);
    add_entry(i_type(OPC_LOAD, 3'd2, 5'd26, 5'd3, 12'h004), 1'b0);
    add_entry(i_type(OPC_LOAD, 3'd2, 5'd27, 5'd0, 12'h7FC), 1'b0);
    add_entry(i_type(OPC_LOAD, 3'd2, 5'd28, 5'd1, 12'h100), 1'b0);
    add_entry(r_type(7'h00, 3'd0, 5'd29, 5'd24, 5'd25), 1'b0);  // RAW on two loads
    add_entry(i_type(OPC_OP_IMM, 3'd0, 5'd26, 5'd0, 12'h055), 1'b0);  // WAW
    add_entry(i_type(OPC_LOAD, 3'd2, 5'd30, 5'd29, 12'h008), 1'b0);
    add_entry(r_type(7'h00, 3'd4, 5'd31, 5'd30, 5'd28), 1'b0);
    add_entry(i_type(OPC_LOAD, 3'd2, 5'd27, 5'd27, 12'h000), 1'b0);
    add_entry(32'h0000_0000, 1'b0);  // Illegal encodings
    add_entry(32'h0011_2023, 1'b0);
    add_entry(i_type(OPC_LOAD, 3'd0, 5'd9, 5'd1, 12'h000), 1'b0);
    add_entry(r_type(7'h01, 3'd0, 5'd9, 5'd1, 5'd2), 1'b0);
    for (int n = 1; n < 32; n++) begin
      add_entry(r_type(7'h00, 3'd6, 5'd0, 5'(n), 5'd0), n == 1);  // Register dump
    end
    limit = 40 * n_tbl + 200;

    repeat (5) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    @(negedge clk);
    check_val("o_rf_wbck.ena", o_rf_wbck.ena, 1'b0);
    check_val("o_agu_valid", o_agu_valid, 1'b0);
    check_val("o_trap", o_trap, 1'b0);
    check_val("o_lsu_ready", o_lsu_ready, 1'b0);
    check_val("o_oitf_empty", o_oitf_empty, 1'b1);

    for (int k = 0; k < n_tbl; k++) begin
      e = tbl[k];
      @(posedge clk);
      #1;
      if (e.drain) begin
        i_valid = 1'b0;
        while (!o_oitf_empty) begin
          @(posedge clk);
          #1;
        end
      end
      i_valid  = 1'b1;
      i_ir     = e.ir;
      i_pc     = e.pc;
      i_rs1idx = e.rs1;
      i_rs2idx = e.rs2;
      @(negedge clk);
      while (!o_ready) begin
        @(negedge clk);
      end
      // Accepted at the coming edge, so no pending load may share a register
      hit = 1'b0;
      foreach (ld_pend[j]) begin
        if ((e.use_rs1 && e.rs1 == ld_pend[j].rd) || (e.use_rs2 && e.rs2 == ld_pend[j].rd)
            || (e.kind != K_ILL && e.rd == ld_pend[j].rd)) hit = 1'b1;
      end
      check_val("pending load overlap", hit, 1'b0);
      check_val("o_oitf_empty", o_oitf_empty, ld_pend.size() == 0);
      case (e.kind)
        K_ALU: begin
          check_val("o_rf_wbck.ena", o_rf_wbck.ena, 1'b1);
          check_val("o_rf_wbck.rdidx", o_rf_wbck.rdidx, e.rd);
          check_val("o_rf_wbck.wdat", o_rf_wbck.wdat, e.val);
          check_val("o_trap", o_trap, 1'b0);
        end
        K_LD: begin
          check_val("o_agu_valid", o_agu_valid, 1'b1);
          check_val("o_agu_req.addr", o_agu_req.addr, e.addr);
          check_val("o_agu_req.itag", o_agu_req.itag, n_ld % OITF_DEPTH);  // Slots in order
          n_ld++;
          if (ld_pend.size() != 0) n_ovl++;
          ld_pend.push_back(e);
        end
        default: begin
          check_val("o_trap", o_trap, 1'b1);
          check_val("o_trap_pc", o_trap_pc, e.pc);
          check_val("o_rf_wbck.ena", o_rf_wbck.ena, 1'b0);
        end
      endcase
    end

    @(posedge clk);
    #1;
    i_valid = 1'b0;
    repeat (2) @(posedge clk);
    if (n_ovl == 0) begin
      n_err++;
      $display("no load was accepted while another load was still outstanding");
    end
    $display("checks %0d, errors %0d", n_chk, n_err);
    if (n_err == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/exu.sv
// Execution unit top; fetch must hold all instruction fields until accepted
`timescale 1ns/1ps

module exu #(
  parameter int OITF_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        i_arst_n,
  // Instruction port
  input  logic                        i_valid,
  output logic                        o_ready,
  input  exu_pkg::instr_u             i_ir,
  input  logic [exu_pkg::XLEN-1:0]    i_pc,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs1idx,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs2idx,
  // Load request
  output logic                        o_agu_valid,
  input  logic                        i_agu_ready,
  output exu_pkg::agu_req_t           o_agu_req,
  // Load return
  input  logic                        i_lsu_valid,
  output logic                        o_lsu_ready,
  input  exu_pkg::lsu_wbck_t          i_lsu_wbck,
  output exu_pkg::rf_wbck_t           o_rf_wbck,
  output logic                        o_trap,
  output logic [exu_pkg::XLEN-1:0]    o_trap_pc,
  output logic                        o_oitf_empty,
  output logic                        o_exu_active
);
  import exu_pkg::*;

  localparam int PTR_W = $clog2(OITF_DEPTH);

  dec_info_t          dec_info;
  logic [XLEN-1:0]    rf_rs1;
  logic [XLEN-1:0]    rf_rs2;
  logic               match_rs1;
  logic               match_rs2;
  logic               match_rd;
  logic               oitf_full;
  logic               oitf_ena;
  logic [PTR_W-1:0]   dis_ptr;
  logic [ITAG_W-1:0]  dis_itag;
  logic [PTR_W-1:0]   ret_ptr;
  logic [RFIDX_W-1:0] ret_rdidx;
  logic               ret_ena;
  logic               alu_valid;
  logic               alu_grant;
  logic [XLEN-1:0]    alu_result;

  exu_decode u_exu_decode (.i_ir(i_ir), .o_info(dec_info));

  exu_regfile u_exu_regfile (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_rs1idx(i_rs1idx), .i_rs2idx(i_rs2idx),
    .o_rs1_dat(rf_rs1), .o_rs2_dat(rf_rs2),
    .i_wbck(o_rf_wbck)
  );

  exu_disp #(.OITF_DEPTH(OITF_DEPTH)) u_exu_disp (
    .i_valid(i_valid), .o_ready(o_ready), .i_info(dec_info),
    .i_match_rs1(match_rs1), .i_match_rs2(match_rs2), .i_match_rd(match_rd),
    .i_oitf_full(oitf_full), .o_oitf_ena(oitf_ena),
    .i_alu_grant(alu_grant), .o_alu_valid(alu_valid),
    .o_agu_valid(o_agu_valid), .i_agu_ready(i_agu_ready), .o_trap(o_trap)
  );

  exu_oitf #(.OITF_DEPTH(OITF_DEPTH)) u_exu_oitf (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_dis_ena(oitf_ena), .i_dis_rdidx(dec_info.rdidx),
    .o_dis_ptr(dis_ptr), .o_full(oitf_full),
    .i_ret_ena(ret_ena), .o_ret_ptr(ret_ptr), .o_ret_rdidx(ret_rdidx),
    .i_rs1idx(i_rs1idx), .i_rs2idx(i_rs2idx), .i_rdidx(dec_info.rdidx),
    .o_match_rs1(match_rs1), .o_match_rs2(match_rs2), .o_match_rd(match_rd),
    .o_empty(o_oitf_empty)
  );

  assign dis_itag = ITAG_W'(dis_ptr);  // Tag field is wider than the pointer

  exu_alu u_exu_alu (
    .i_info(dec_info), .i_rs1_dat(rf_rs1), .i_rs2_dat(rf_rs2),
    .o_result(alu_result), .o_agu_req(o_agu_req), .i_dis_ptr(dis_itag)
  );

  exu_wbck #(.OITF_DEPTH(OITF_DEPTH)) u_exu_wbck (
    .i_lsu_valid(i_lsu_valid), .o_lsu_ready(o_lsu_ready), .i_lsu_wbck(i_lsu_wbck),
    .i_ret_ptr(ret_ptr), .i_oitf_empty(o_oitf_empty), .i_ret_rdidx(ret_rdidx),
    .o_ret_ena(ret_ena),
    .i_alu_valid(alu_valid), .i_alu_rdidx(dec_info.rdidx), .i_alu_wdat(alu_result),
    .o_alu_grant(alu_grant), .o_wbck(o_rf_wbck)
  );

  assign o_trap_pc    = i_pc;
  assign o_exu_active = ~o_oitf_empty | i_valid;

endmodule

//--- verilog/exu_wbck.sv
// Write-back arbiter; load returns win, and must come back in table order
`timescale 1ns/1ps

module exu_wbck #(
  parameter int OITF_DEPTH = 4,
  localparam int PTR_W     = $clog2(OITF_DEPTH)
) (
  input  logic                        i_lsu_valid,
  output logic                        o_lsu_ready,
  input  exu_pkg::lsu_wbck_t          i_lsu_wbck,
  input  logic [PTR_W-1:0]            i_ret_ptr,
  input  logic                        i_oitf_empty,
  input  logic [exu_pkg::RFIDX_W-1:0] i_ret_rdidx,
  output logic                        o_ret_ena,
  input  logic                        i_alu_valid,
  input  logic [exu_pkg::RFIDX_W-1:0] i_alu_rdidx,
  input  logic [exu_pkg::XLEN-1:0]    i_alu_wdat,
  output logic                        o_alu_grant,
  output exu_pkg::rf_wbck_t           o_wbck
);
  import exu_pkg::*;

  logic ret_hit;

  // Only the oldest entry may come back
  assign ret_hit     = (i_lsu_wbck.itag == ITAG_W'(i_ret_ptr));
  assign o_lsu_ready = ~i_oitf_empty & ret_hit;
  assign o_ret_ena   = i_lsu_valid & o_lsu_ready;

  assign o_alu_grant = ~o_ret_ena;  // ALU waits a cycle

  ////////////////////////////////////////////////////////////////////////////
  // Register file port

  assign o_wbck.ena   = o_ret_ena | (i_alu_valid & o_alu_grant);
  assign o_wbck.rdidx = o_ret_ena ? i_ret_rdidx : i_alu_rdidx;
  assign o_wbck.wdat  = o_ret_ena ? i_lsu_wbck.wdat : i_alu_wdat;

endmodule

//--- verilog/exu_alu.sv
// Single-cycle integer datapath; shifts use the low five bits of operand 2 only
`timescale 1ns/1ps

module exu_alu (
  input  exu_pkg::dec_info_t         i_info,
  input  logic [exu_pkg::XLEN-1:0]   i_rs1_dat,
  input  logic [exu_pkg::XLEN-1:0]   i_rs2_dat,
  output logic [exu_pkg::XLEN-1:0]   o_result,
  output exu_pkg::agu_req_t          o_agu_req,
  input  logic [exu_pkg::ITAG_W-1:0] i_dis_ptr
);
  import exu_pkg::*;

  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] op2_x;
  logic [XLEN:0]   add_res;  // Carry kept for SLTU
  logic            sub_en;
  logic            lt_s;
  logic            lt_u;
  logic [4:0]      shamt;

  ////////////////////////////////////////////////////////////////////////////
  // Operand select

  assign op1 = i_info.rs1en ? i_rs1_dat : '0;  // LUI adds imm to zero
  assign op2 = i_info.use_imm ? i_info.imm : i_rs2_dat;

  // Shared adder for ADD, SUB, compares and load address
  assign sub_en  = (i_info.alu_op == ALU_SUB)
                 | (i_info.alu_op == ALU_SLT)
                 | (i_info.alu_op == ALU_SLTU);
  assign op2_x   = sub_en ? ~op2 : op2;
  assign add_res = {1'b0, op1} + {1'b0, op2_x} + {{XLEN{1'b0}}, sub_en};

  assign lt_u  = ~add_res[XLEN];  // No carry out means borrow
  assign lt_s  = (op1[XLEN-1] ^ op2[XLEN-1]) ? op1[XLEN-1] : add_res[XLEN-1];
  assign shamt = op2[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // Result mux

  always_comb begin
    case (i_info.alu_op)
      ALU_ADD,
      ALU_SUB:  o_result = add_res[XLEN-1:0];
      ALU_AND:  o_result = op1 & op2;
      ALU_OR:   o_result = op1 | op2;
      ALU_XOR:  o_result = op1 ^ op2;
      ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_SLL:  o_result = op1 << shamt;
      ALU_SRL:  o_result = op1 >> shamt;
      ALU_SRA:  o_result = $unsigned($signed(op1) >>> shamt);
      default:  o_result = add_res[XLEN-1:0];
    endcase
  end

  // Load request tagged with the slot it will occupy
  assign o_agu_req.addr = add_res[XLEN-1:0];
  assign o_agu_req.itag = i_dis_ptr;

endmodule

//--- verilog/exu_oitf.sv
// Outstanding load table; depth must be at least 2, entries retire strictly in allocation order
`timescale 1ns/1ps

module exu_oitf #(
  parameter int OITF_DEPTH = 4,
  localparam int PTR_W     = $clog2(OITF_DEPTH)
) (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic                        i_dis_ena,
  input  logic [exu_pkg::RFIDX_W-1:0] i_dis_rdidx,
  output logic [PTR_W-1:0]            o_dis_ptr,
  output logic                        o_full,
  input  logic                        i_ret_ena,
  output logic [PTR_W-1:0]            o_ret_ptr,
  output logic [exu_pkg::RFIDX_W-1:0] o_ret_rdidx,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs1idx,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs2idx,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rdidx,
  output logic                        o_match_rs1,
  output logic                        o_match_rs2,
  output logic                        o_match_rd,
  output logic                        o_empty
);
  import exu_pkg::*;

  localparam logic [PTR_W-1:0] LAST = PTR_W'(OITF_DEPTH - 1);

  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic               wr_wrap_q;  // Toggles on each pass
  logic               rd_wrap_q;
  logic [OITF_DEPTH-1:0] vld_q;
  logic [RFIDX_W-1:0] rdidx_q [OITF_DEPTH];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      wr_wrap_q <= 1'b0;
      rd_wrap_q <= 1'b0;
      vld_q     <= '0;
    end else begin
      if (i_dis_ena) begin
        vld_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q        <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
        if (wr_ptr_q == LAST) wr_wrap_q <= ~wr_wrap_q;
      end
      if (i_ret_ena) begin
        vld_q[rd_ptr_q] <= 1'b0;  // Never the slot being allocated
        rd_ptr_q        <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
        if (rd_ptr_q == LAST) rd_wrap_q <= ~rd_wrap_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_dis_ena) rdidx_q[wr_ptr_q] <= i_dis_rdidx;
  end

  // Destination compare against every live entry
  always_comb begin
    o_match_rs1 = 1'b0;
    o_match_rs2 = 1'b0;
    o_match_rd  = 1'b0;
    for (int i = 0; i < OITF_DEPTH; i++) begin
      o_match_rs1 = o_match_rs1 | (vld_q[i] & (rdidx_q[i] == i_rs1idx));
      o_match_rs2 = o_match_rs2 | (vld_q[i] & (rdidx_q[i] == i_rs2idx));
      o_match_rd  = o_match_rd  | (vld_q[i] & (rdidx_q[i] == i_rdidx));
    end
  end

  assign o_dis_ptr   = wr_ptr_q;
  assign o_ret_ptr   = rd_ptr_q;
  assign o_ret_rdidx = rdidx_q[rd_ptr_q];
  assign o_full      = (wr_ptr_q == rd_ptr_q) & (wr_wrap_q != rd_wrap_q);
  assign o_empty     = (wr_ptr_q == rd_ptr_q) & (wr_wrap_q == rd_wrap_q);

endmodule

//--- verilog/exu_disp.sv
// Dispatch is combinational; a load without any table entries (OITF_DEPTH of 0) traps
`timescale 1ns/1ps

module exu_disp #(
  parameter int OITF_DEPTH = 4
) (
  input  logic               i_valid,
  output logic               o_ready,
  input  exu_pkg::dec_info_t i_info,
  input  logic               i_match_rs1,
  input  logic               i_match_rs2,
  input  logic               i_match_rd,
  input  logic               i_oitf_full,
  output logic               o_oitf_ena,
  input  logic               i_alu_grant,
  output logic               o_alu_valid,
  output logic               o_agu_valid,
  input  logic               i_agu_ready,
  output logic               o_trap
);

  localparam bit LONGP_EN = (OITF_DEPTH > 0);

  logic hazard;
  logic is_ld;
  logic ld_ok;
  logic ilegl;

  // RAW on either source, WAW on the destination
  assign hazard = (i_info.rs1en & i_match_rs1)
                | (i_info.rs2en & i_match_rs2)
                | (i_info.rdwen & i_match_rd);

  assign is_ld = i_info.is_load & LONGP_EN;
  assign ilegl = i_info.ilegl | (i_info.is_load & ~LONGP_EN);
  assign ld_ok = ~hazard & ~i_oitf_full;

  ////////////////////////////////////////////////////////////////////////////
  // Long-pipe path

  assign o_agu_valid = i_valid & is_ld & ld_ok;
  assign o_oitf_ena  = o_agu_valid & i_agu_ready;  // Allocate on request accept

  ////////////////////////////////////////////////////////////////////////////
  // Single-cycle ALU path

  // Arbiter grant is applied in write-back
  assign o_alu_valid = i_valid & ~is_ld & ~hazard & i_info.rdwen & ~ilegl;

  assign o_ready = is_ld ? (ld_ok & i_agu_ready)
                         : (~hazard & i_alu_grant);

  assign o_trap = i_valid & o_ready & ilegl;  // Pulses on acceptance only

endmodule

//--- verilog/exu_decode.sv
// Decodes only OP, OP-IMM, LUI and LW; any other encoding comes out as illegal with no enables
`timescale 1ns/1ps

module exu_decode (
  input  exu_pkg::instr_u    i_ir,
  output exu_pkg::dec_info_t o_info
);
  import exu_pkg::*;

  logic       f7_zero;
  logic       f7_alt;
  logic       alt_ok;
  logic       legal;
  alu_op_e    f3_op;
  logic [2:0] f3;

  assign f3      = i_ir.r_fmt.funct3;
  assign f7_zero = (i_ir.r_fmt.funct7 == 7'b0000000);
  assign f7_alt  = (i_ir.r_fmt.funct7 == 7'b0100000);  // SUB / SRA flavour
  assign alt_ok  = (f3 == 3'b000) | (f3 == 3'b101);

  // Base operation from funct3 alone
  always_comb begin
    case (f3)
      3'b000:  f3_op = ALU_ADD;
      3'b001:  f3_op = ALU_SLL;
      3'b010:  f3_op = ALU_SLT;
      3'b011:  f3_op = ALU_SLTU;
      3'b100:  f3_op = ALU_XOR;
      3'b101:  f3_op = ALU_SRL;
      3'b110:  f3_op = ALU_OR;
      default: f3_op = ALU_AND;
    endcase
  end

  always_comb begin
    o_info        = '0;
    o_info.alu_op = ALU_ADD;
    o_info.rdidx  = i_ir.r_fmt.rd;
    legal         = 1'b0;
    case (i_ir.r_fmt.opcode)
      OPC_OP: begin
        o_info.rs1en  = 1'b1;
        o_info.rs2en  = 1'b1;
        o_info.rdwen  = 1'b1;
        o_info.alu_op = f7_alt ? ((f3 == 3'b000) ? ALU_SUB : ALU_SRA) : f3_op;
        legal         = f7_zero | (f7_alt & alt_ok);
      end
      OPC_OP_IMM: begin
        o_info.rs1en   = 1'b1;
        o_info.use_imm = 1'b1;
        o_info.rdwen   = 1'b1;
        o_info.imm     = {{20{i_ir.i_fmt.imm12[11]}}, i_ir.i_fmt.imm12};
        o_info.alu_op  = ((f3 == 3'b101) && f7_alt) ? ALU_SRA : f3_op;
        // Shift immediates still carry a funct7 in the upper bits
        if (f3 == 3'b001)      legal = f7_zero;
        else if (f3 == 3'b101) legal = f7_zero | f7_alt;
        else                   legal = 1'b1;
      end
      OPC_LUI: begin
        o_info.use_imm = 1'b1;
        o_info.rdwen   = 1'b1;
        o_info.imm     = {i_ir.r_fmt.funct7, i_ir.r_fmt.rs2, i_ir.r_fmt.rs1, f3, 12'h000};
        legal          = 1'b1;
      end
      OPC_LOAD: begin
        o_info.is_load = 1'b1;
        o_info.rs1en   = 1'b1;
        o_info.use_imm = 1'b1;
        o_info.rdwen   = 1'b1;
        o_info.imm     = {{20{i_ir.i_fmt.imm12[11]}}, i_ir.i_fmt.imm12};
        legal          = (f3 == 3'b010);  // LW only
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      o_info.is_load = 1'b0;
      o_info.rs1en   = 1'b0;
      o_info.rs2en   = 1'b0;
      o_info.rdwen   = 1'b0;
    end
    o_info.ilegl = ~legal;
  end

endmodule

//--- verilog/exu_regfile.sv
// Integer register file; reads are combinational, a write shows up after the clock edge
`timescale 1ns/1ps

module exu_regfile (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs1idx,
  input  logic [exu_pkg::RFIDX_W-1:0] i_rs2idx,
  output logic [exu_pkg::XLEN-1:0]    o_rs1_dat,
  output logic [exu_pkg::XLEN-1:0]    o_rs2_dat,
  input  exu_pkg::rf_wbck_t           i_wbck
);
  import exu_pkg::*;

  logic [XLEN-1:0] rf_q [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wbck.ena && (i_wbck.rdidx != '0)) begin
      rf_q[i_wbck.rdidx] <= i_wbck.wdat;
    end
  end

  // Index zero is hardwired
  assign o_rs1_dat = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2_dat = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

endmodule

//--- verilog/exu_pkg.sv
// Shared types for the execution unit; ITAG_W bounds the table depth to 16 entries
package exu_pkg;

  localparam int XLEN    = 32;
  localparam int RFIDX_W = 5;
  localparam int ITAG_W  = 4;  // Tag field width on the load ports

  // Major opcodes kept in this subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [RFIDX_W-1:0] rs2;
    logic [RFIDX_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [RFIDX_W-1:0] rd;
    logic [6:0]         opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]        imm12;
    logic [RFIDX_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [RFIDX_W-1:0] rd;
    logic [6:0]         opcode;
  } i_fmt_t;

  // Same 32-bit word seen as register or immediate format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  typedef struct packed {
    alu_op_e            alu_op;
    logic               is_load;
    logic               use_imm;  // Operand 2 from imm
    logic               rs1en;
    logic               rs2en;
    logic               rdwen;
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    imm;
    logic               ilegl;
  } dec_info_t;

  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic [ITAG_W-1:0] itag;
  } agu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   wdat;
    logic [ITAG_W-1:0] itag;
  } lsu_wbck_t;

  typedef struct packed {
    logic               ena;
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    wdat;
  } rf_wbck_t;

endpackage
